// ==== isaPkg.sv ====
`default_nettype none

package isaPkg;

  ////////////////////////////////////////////////////////////
  // Widths with a meaning
  ////////////////////////////////////////////////////////////
  localparam int wordW   = 16;              // Register, immediate and PC width
  localparam int irW     = 32;              // Instruction word
  localparam int opW     = 8;               // Opcode field
  localparam int numRegs = 8;               // Scalar file R0..R7
  localparam int regIdxW = $clog2(numRegs);

  typedef logic [wordW-1:0]   wordT;
  typedef logic [irW-1:0]     irT;
  typedef logic [regIdxW-1:0] regIdxT;
  typedef logic [2:0]         condT;        // {negative, zero, positive}

  ////////////////////////////////////////////////////////////
  // Instruction field positions
  ////////////////////////////////////////////////////////////
  // Register fields are four bits wide in the encoding,
  // only the low regIdxW bits select a register
  localparam int opLo   = 24;               // 31:24
  localparam int destLo = 20;               // 23:20
  localparam int src1Lo = 16;               // 19:16
  localparam int src2Lo = 8;                // 11:8
  localparam int immLo  = 0;                // 15:0, already full width

  localparam regIdxT linkReg = regIdxT'(7); // Return address of JSR and JSRR

  // One-hot condition codes
  localparam condT ccNeg  = 3'b100;
  localparam condT ccZero = 3'b010;
  localparam condT ccPos  = 3'b001;

  ////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////
  typedef enum logic [opW-1:0] {
    ADD   = 8'h00,
    ADDI  = 8'h01,
    AND   = 8'h02,
    ANDI  = 8'h03,
    MOV   = 8'h08,                          // Reads src2 field, writes src1 field
    MOVI  = 8'h09,                          // Writes src1 field
    LDW   = 8'h10,
    STW   = 8'h11,                          // Dest field holds the store data register
    BRN   = 8'h20,
    BRZ   = 8'h21,
    BRP   = 8'h22,
    BRNZ  = 8'h23,
    BRNP  = 8'h24,
    BRZP  = 8'h25,
    BRNZP = 8'h26,
    JMP   = 8'h28,
    JSR   = 8'h29,
    JSRR  = 8'h2A,
    NOP   = 8'hFF                           // Also stands in for any unknown code
  } opcodeE;

endpackage

`default_nettype wire

// ==== pipePkg.sv ====
`default_nettype none

package pipePkg;

  import isaPkg::*;

  ////////////////////////////////////////////////////////////
  // Stage boundary bundles
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic   valid;             // Fetch offers an instruction
    wordT   pc;
    irT     ir;
  } fetchT;

  typedef struct packed {
    logic   enable;            // Result returning this cycle
    regIdxT regIdx;
    wordT   data;
  } writeBackT;

  typedef struct packed {
    logic   valid;
    wordT   pc;
    opcodeE opcode;
    wordT   src1Value;
    wordT   src2Value;
    wordT   storeValue;        // STW data, read through the dest field
    regIdxT destRegIdx;
    wordT   imm;
    logic   branchTaken;
  } issueT;

  ////////////////////////////////////////////////////////////
  // Decoder output, shared inside the stage
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    opcodeE opcode;            // Unknown codes already folded to NOP
    regIdxT src1Idx;
    regIdxT src2Idx;
    regIdxT destIdx;           // Src1 field for MOV and MOVI
    logic   usesSrc1;
    logic   usesSrc2;
    logic   writesDest;
    logic   isCondBranch;      // BRN .. BRNZP
    logic   isControl;         // Any branch or jump
    logic   isLink;            // JSR, JSRR
    condT   branchMask;
  } decodedT;

endpackage

`default_nettype wire

// ==== instrDecoder.sv ====
`default_nettype none
`timescale 1ns/10ps

module instrDecoder
  import isaPkg::*, pipePkg::*;
(
  input  irT      ir,
  output decodedT decoded
);

  logic [opW-1:0] opField;
  regIdxT         destField;
  regIdxT         src1Field;
  regIdxT         src2Field;
  opcodeE         opcode;
  condT           branchMask;             // Taken flags per branch flavour

  // Raw fields, low bits of each register field only
  assign opField   = ir[opLo +: opW];
  assign destField = ir[destLo +: regIdxW];
  assign src1Field = ir[src1Lo +: regIdxW];
  assign src2Field = ir[src2Lo +: regIdxW];

  ////////////////////////////////////////////////////////////
  // Opcode legalisation
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (opField)
      ADD, ADDI, AND, ANDI, MOV, MOVI, LDW, STW,
      BRN, BRZ, BRP, BRNZ, BRNP, BRZP, BRNZP,
      JMP, JSR, JSRR: opcode = opcodeE'(opField);
      default:        opcode = NOP;               // Unknown behaves as NOP
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Operand use and control class
  ////////////////////////////////////////////////////////////
  always_comb begin
    decoded              = '0;
    decoded.opcode       = opcode;
    decoded.src1Idx      = src1Field;
    decoded.src2Idx      = src2Field;
    decoded.destIdx      = destField;
    decoded.branchMask   = branchMask;
    case (opcode)
      ADD, AND: begin
        decoded.usesSrc1   = 1'b1;
        decoded.usesSrc2   = 1'b1;
        decoded.writesDest = 1'b1;
      end
      ADDI, ANDI, LDW: begin                      // One register source plus imm
        decoded.usesSrc1   = 1'b1;
        decoded.writesDest = 1'b1;
      end
      MOV: begin
        decoded.usesSrc2   = 1'b1;
        decoded.writesDest = 1'b1;
        decoded.destIdx    = src1Field;           // Result lands in the src1 field
      end
      MOVI: begin
        decoded.writesDest = 1'b1;
        decoded.destIdx    = src1Field;
      end
      // Base address only here, store data via destIdx
      STW:   decoded.usesSrc1 = 1'b1;
      BRN, BRZ, BRP, BRNZ, BRNP, BRZP, BRNZP: begin
        decoded.isCondBranch = 1'b1;
        decoded.isControl    = 1'b1;
      end
      JMP: begin
        decoded.usesSrc1  = 1'b1;                 // Target register
        decoded.isControl = 1'b1;
      end
      JSR: begin
        decoded.isControl = 1'b1;
        decoded.isLink    = 1'b1;
      end
      JSRR: begin
        decoded.usesSrc1  = 1'b1;
        decoded.isControl = 1'b1;
        decoded.isLink    = 1'b1;
      end
      default: ;                                  // NOP uses nothing
    endcase
  end

  // Condition mask per branch flavour
  always_comb begin
    case (opcode)
      BRN:     branchMask = ccNeg;
      BRZ:     branchMask = ccZero;
      BRP:     branchMask = ccPos;
      BRNZ:    branchMask = ccNeg | ccZero;
      BRNP:    branchMask = ccNeg | ccPos;
      BRZP:    branchMask = ccZero | ccPos;
      BRNZP:   branchMask = ccNeg | ccZero | ccPos;
      default: branchMask = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== registerFile.sv ====
`default_nettype none
`timescale 1ns/10ps

module registerFile
  import isaPkg::*, pipePkg::*;
(
  input  logic      I_CLOCK,
  input  logic      rst,
  input  writeBackT writeBack,
  input  logic      linkEnable,   // JSR / JSRR accepted this cycle
  input  wordT      linkData,     // PC of the linking instruction
  input  regIdxT    rdIdxA,       // First source
  input  regIdxT    rdIdxB,       // Second source
  input  regIdxT    rdIdxC,       // Store data
  output wordT      rdDataA,
  output wordT      rdDataB,
  output wordT      rdDataC
);

  wordT regs [numRegs];

  ////////////////////////////////////////////////////////////
  // Write side
  ////////////////////////////////////////////////////////////
  always_ff @(posedge I_CLOCK) begin
    if (rst) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (writeBack.enable) begin
        regs[writeBack.regIdx] <= writeBack.data;
      end
      // Comes last so a link beats a writeback to R7
      if (linkEnable) begin
        regs[linkReg] <= linkData;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read side with write-through
  ////////////////////////////////////////////////////////////
  function automatic wordT readPort(regIdxT idx, wordT stored, writeBackT wb);
    if (wb.enable && (wb.regIdx == idx)) begin
      return wb.data;                     // Same-cycle writeback forwarded
    end
    return stored;
  endfunction

  assign rdDataA = readPort(rdIdxA, regs[rdIdxA], writeBack);
  assign rdDataB = readPort(rdIdxB, regs[rdIdxB], writeBack);
  assign rdDataC = readPort(rdIdxC, regs[rdIdxC], writeBack);

endmodule

`default_nettype wire

// ==== scoreboard.sv ====
`default_nettype none
`timescale 1ns/10ps

module scoreboard
  import isaPkg::*, pipePkg::*;
(
  input  logic      I_CLOCK,
  input  logic      rst,
  input  decodedT   decoded,
  input  logic      accept,      // Instruction leaves decode this cycle
  input  writeBackT writeBack,
  output logic      hazard,      // Some used source still in flight
  output logic      anyBusy      // At least one writer outstanding
);

  logic [numRegs-1:0] busy;      // One bit per scalar register
  logic               usesStore;

  ////////////////////////////////////////////////////////////
  // Busy bits
  ////////////////////////////////////////////////////////////
  always_ff @(posedge I_CLOCK) begin
    if (rst) begin
      busy <= '0;
    end else begin
      if (writeBack.enable) begin
        busy[writeBack.regIdx] <= 1'b0;     // Result has arrived
      end
      if (accept && decoded.writesDest) begin
        busy[decoded.destIdx] <= 1'b1;      // Set wins over a same-cycle clear
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Source check
  ////////////////////////////////////////////////////////////
  // Busy and not rescued by this cycle's writeback
  function automatic logic blocked(regIdxT idx, logic [numRegs-1:0] busyVec,
                                   writeBackT wb);
    logic bypass;
    bypass = wb.enable && (wb.regIdx == idx);
    return busyVec[idx] && !bypass;
  endfunction

  // STW also reads its dest field as store data
  assign usesStore = (decoded.opcode == STW);

  assign hazard = (decoded.usesSrc1 && blocked(decoded.src1Idx, busy, writeBack))
               || (decoded.usesSrc2 && blocked(decoded.src2Idx, busy, writeBack))
               || (usesStore        && blocked(decoded.destIdx, busy, writeBack));

  assign anyBusy = |busy;

endmodule

`default_nettype wire

// ==== branchUnit.sv ====
`default_nettype none
`timescale 1ns/10ps

module branchUnit
  import isaPkg::*, pipePkg::*;
(
  input  logic      I_CLOCK,
  input  logic      rst,
  input  decodedT   decoded,
  input  writeBackT writeBack,
  input  logic      anyBusy,
  output logic      branchReady,  // No writer in flight
  output logic      branchTaken
);

  condT cc;                       // Follows the last writeback

  ////////////////////////////////////////////////////////////
  // Condition-code register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge I_CLOCK) begin
    if (rst) begin
      cc <= ccZero;
    end else if (writeBack.enable) begin
      if (writeBack.data[wordW-1]) begin
        cc <= ccNeg;              // Sign bit set
      end else if (writeBack.data == '0) begin
        cc <= ccZero;
      end else begin
        cc <= ccPos;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Readiness and decision
  ////////////////////////////////////////////////////////////
  // Pending results may still move cc, so wait them all out.
  // A writeback in this very cycle is not counted as done.
  assign branchReady = !anyBusy;

  always_comb begin
    if (decoded.isCondBranch) begin
      branchTaken = |(decoded.branchMask & cc);  // BRNZP mask is all ones
    end else if (decoded.isControl) begin
      branchTaken = 1'b1;                        // JMP, JSR, JSRR
    end else begin
      branchTaken = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== decodeStage.sv ====
`default_nettype none
`timescale 1ns/10ps

module decodeStage
  import isaPkg::*, pipePkg::*;
(
  input  logic      I_CLOCK,
  input  logic      rst,
  input  fetchT     fetch,
  input  writeBackT writeBack,
  output issueT     issue,
  output logic      depStall,     // Hold fetch, combinational
  output logic      branchStall   // Registered, aligned with issue
);

  decodedT dec;
  logic    hazard;
  logic    anyBusy;
  logic    branchReady;
  logic    branchTaken;
  logic    accept;
  logic    linkEnable;
  wordT    linkData;
  wordT    src1Value;
  wordT    src2Value;
  wordT    storeValue;

  ////////////////////////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////////////////////////
  instrDecoder uDecoder (
    .ir      (fetch.ir),
    .decoded (dec)
  );

  registerFile uRegFile (
    .I_CLOCK    (I_CLOCK),
    .rst        (rst),
    .writeBack  (writeBack),
    .linkEnable (linkEnable),
    .linkData   (linkData),
    .rdIdxA     (dec.src1Idx),
    .rdIdxB     (dec.src2Idx),
    .rdIdxC     (dec.destIdx),  // Store data for STW
    .rdDataA    (src1Value),
    .rdDataB    (src2Value),
    .rdDataC    (storeValue)
  );

  scoreboard uScoreboard (
    .I_CLOCK   (I_CLOCK),
    .rst       (rst),
    .decoded   (dec),
    .accept    (accept),
    .writeBack (writeBack),
    .hazard    (hazard),
    .anyBusy   (anyBusy)
  );

  branchUnit uBranch (
    .I_CLOCK     (I_CLOCK),
    .rst         (rst),
    .decoded     (dec),
    .writeBack   (writeBack),
    .anyBusy     (anyBusy),
    .branchReady (branchReady),
    .branchTaken (branchTaken)
  );

  ////////////////////////////////////////////////////////////
  // Stall and accept
  ////////////////////////////////////////////////////////////
  assign depStall   = fetch.valid && (hazard || (dec.isCondBranch && !branchReady));
  assign accept     = fetch.valid && !depStall;
  assign linkEnable = accept && dec.isLink;       // R7 gets the return PC
  assign linkData   = fetch.pc;

  ////////////////////////////////////////////////////////////
  // Issue register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge I_CLOCK) begin
    if (rst) begin
      issue.valid <= 1'b0;
      branchStall <= 1'b0;
    end else begin
      issue.valid <= accept;                      // Bubble when nothing accepted
      branchStall <= accept && dec.isControl;
    end
    if (accept) begin                             // Payload only, no reset
      issue.pc          <= fetch.pc;
      issue.opcode      <= dec.opcode;
      issue.src1Value   <= src1Value;
      issue.src2Value   <= src2Value;
      issue.storeValue  <= storeValue;
      issue.destRegIdx  <= dec.destIdx;
      issue.imm         <= fetch.ir[immLo +: wordW];
      issue.branchTaken <= branchTaken;
    end
  end

endmodule

`default_nettype wire

// ==== decodeStage_asserts.sv ====
`default_nettype none
`timescale 1ns/10ps

module decodeStageAsserts
  import pipePkg::*;
(
  input logic  I_CLOCK,
  input logic  rst,
  input fetchT fetch,
  input issueT issue,
  input logic  depStall,
  input logic  branchStall
);

  ////////////////////////////////////////////////////////////
  // Stall and issue protocol
  ////////////////////////////////////////////////////////////
  // Branch pulse only rides on a real issue
  pulseHasIssue: assert property (@(posedge I_CLOCK) disable iff (rst)
    branchStall |-> issue.valid)
    else $error("branchStall high without issue.valid");

  stallNeedsFetch: assert property (@(posedge I_CLOCK) disable iff (rst)
    depStall |-> fetch.valid)       // No stall on a bubble
    else $error("depStall high while fetch.valid is low");

  // A held instruction leaves a bubble behind it
  stallGivesBubble: assert property (@(posedge I_CLOCK) disable iff (rst)
    (fetch.valid && depStall) |=> !issue.valid)
    else $error("issue.valid high after a stalled cycle");

endmodule

bind decodeStage decodeStageAsserts uAsserts (
  .I_CLOCK     (I_CLOCK),
  .rst         (rst),
  .fetch       (fetch),
  .issue       (issue),
  .depStall    (depStall),
  .branchStall (branchStall)
);

`default_nettype wire

// ==== tbDecodeStage.sv ====
`default_nettype none
`timescale 1ns/10ps

module tbDecodeStage
  import isaPkg::*, pipePkg::*;
();

  localparam int numCycles  = 3000;
  localparam int stallLimit = 200;     // Longest hold of one instruction

  logic      I_CLOCK;
  logic      rst;
  fetchT     fetch;
  writeBackT writeBack;
  issueT     issue;
  logic      depStall;
  logic      branchStall;

  // Reference model state
  wordT               mRegs [numRegs];
  logic [numRegs-1:0] mBusy;
  condT               mCc;
  issueT              expIssue;         // Predicted for the next edge
  logic               expBranchStall;
  logic               held;             // Fetch repeats its instruction
  int                 holdCount;
  logic [31:0]        rngState;

  opcodeE validOps [18] = '{ADD, ADDI, AND, ANDI, MOV, MOVI, LDW, STW, BRN, BRZ, BRP,
                            BRNZ, BRNP, BRZP, BRNZP, JMP, JSR, JSRR};

  decodeStage i_dut (
    .I_CLOCK     (I_CLOCK),
    .rst         (rst),
    .fetch       (fetch),
    .writeBack   (writeBack),
    .issue       (issue),
    .depStall    (depStall),
    .branchStall (branchStall)
  );

  always #2 I_CLOCK = ~I_CLOCK;         // 4 ns period

  ////////////////////////////////////////////////////////////
  // Random numbers and checking
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] nextRand();
    rngState = xorshift32(rngState);
    return rngState;
  endfunction

  task automatic checkValue(input wordT got, input wordT exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////
  function automatic decodedT modelDecode(irT ir);
    decodedT d;
    d         = '0;
    d.opcode  = NOP;                    // Anything off the list
    d.src1Idx = ir[18:16];
    d.src2Idx = ir[10:8];
    d.destIdx = ir[22:20];
    foreach (validOps[i]) begin
      if (ir[31:24] == validOps[i]) d.opcode = validOps[i];
    end
    case (d.opcode)
      ADD, AND:        {d.usesSrc1, d.usesSrc2, d.writesDest} = 3'b111;
      ADDI, ANDI, LDW: {d.usesSrc1, d.writesDest} = 2'b11;
      MOV: begin
        {d.usesSrc2, d.writesDest} = 2'b11;
        d.destIdx = ir[18:16];          // Result goes to the src1 field
      end
      MOVI: begin
        d.writesDest = 1'b1;
        d.destIdx    = ir[18:16];
      end
      STW:   d.usesSrc1 = 1'b1;         // Store data checked separately
      JMP:   {d.usesSrc1, d.isControl} = 2'b11;
      JSR:   {d.isControl, d.isLink} = 2'b11;
      JSRR:  {d.usesSrc1, d.isControl, d.isLink} = 3'b111;
      BRN:   d.branchMask = 3'b100;
      BRZ:   d.branchMask = 3'b010;
      BRP:   d.branchMask = 3'b001;
      BRNZ:  d.branchMask = 3'b110;
      BRNP:  d.branchMask = 3'b101;
      BRZP:  d.branchMask = 3'b011;
      BRNZP: d.branchMask = 3'b111;
      default: ;
    endcase
    d.isCondBranch = (d.branchMask != 3'b000);
    d.isControl    = d.isControl | d.isCondBranch;
    return d;
  endfunction

  function logic blocked(regIdxT idx);
    return mBusy[idx] && !(writeBack.enable && (writeBack.regIdx == idx));
  endfunction

  function wordT readReg(regIdxT idx);
    if (writeBack.enable && (writeBack.regIdx == idx)) begin
      return writeBack.data;            // Write-through
    end
    return mRegs[idx];
  endfunction

  // Runs once inputs have settled, predicts depStall now and issue next edge
  task automatic modelCycle();
    decodedT d;
    logic    expStall;
    logic    accept;
    d        = modelDecode(fetch.ir);
    expStall = fetch.valid && ((d.usesSrc1 && blocked(d.src1Idx))
                            || (d.usesSrc2 && blocked(d.src2Idx))
                            || ((d.opcode == STW) && blocked(d.destIdx))
                            || (d.isCondBranch && (mBusy != '0)));
    checkValue(wordT'(depStall), wordT'(expStall), "depStall");
    accept         = fetch.valid && !expStall;
    held           = fetch.valid && expStall;
    expIssue.valid = accept;
    expBranchStall = accept && d.isControl;
    if (accept) begin
      expIssue.pc          = fetch.pc;
      expIssue.opcode      = d.opcode;
      expIssue.src1Value   = readReg(d.src1Idx);
      expIssue.src2Value   = readReg(d.src2Idx);
      expIssue.storeValue  = readReg(d.destIdx);
      expIssue.destRegIdx  = d.destIdx;
      expIssue.imm         = fetch.ir[15:0];
      expIssue.branchTaken = d.isCondBranch ? |(d.branchMask & mCc) : d.isControl;
    end
    if (writeBack.enable) begin
      mRegs[writeBack.regIdx] = writeBack.data;
      mBusy[writeBack.regIdx] = 1'b0;
      mCc = writeBack.data[15] ? 3'b100 : ((writeBack.data == '0) ? 3'b010 : 3'b001);
    end
    if (accept && d.writesDest) mBusy[d.destIdx] = 1'b1;  // Set beats clear
    if (accept && d.isLink) mRegs[linkReg] = fetch.pc;     // Link beats writeback
  endtask

  task automatic checkIssue();
    checkValue(wordT'(issue.valid), wordT'(expIssue.valid), "issue.valid");
    checkValue(wordT'(branchStall), wordT'(expBranchStall), "branchStall");
    if (expIssue.valid) begin
      checkValue(issue.pc, expIssue.pc, "issue.pc");
      checkValue(wordT'(issue.opcode), wordT'(expIssue.opcode), "issue.opcode");
      checkValue(issue.src1Value, expIssue.src1Value, "issue.src1Value");
      checkValue(issue.src2Value, expIssue.src2Value, "issue.src2Value");
      checkValue(issue.storeValue, expIssue.storeValue, "issue.storeValue");
      checkValue(wordT'(issue.destRegIdx), wordT'(expIssue.destRegIdx), "issue.destRegIdx");
      checkValue(issue.imm, expIssue.imm, "issue.imm");
      checkValue(wordT'(issue.branchTaken), wordT'(expIssue.branchTaken), "issue.branchTaken");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  task automatic driveInputs();
    logic [31:0] r;
    logic [31:0] opR;
    logic [31:0] f;
    logic [7:0]  opByte;
    int          sel;
    regIdxT      idx;
    if (!held) begin                    // New instruction or bubble
      r   = nextRand();
      opR = nextRand();
      f   = nextRand();
      sel = int'(opR % 32'd20);
      if (sel < 18) begin
        opByte = 8'(validOps[sel]);
      end else begin
        opByte = opR[15:8];             // Mostly unknown codes
      end
      fetch.valid = (r[2:0] != 3'd0);
      fetch.pc    = r[31:16];
      fetch.ir    = {opByte, f[23:0]};
    end
    r   = nextRand();
    idx = r[2:0];
    writeBack = '0;
    if (r[7:5] == 3'd0) begin
      writeBack.enable = 1'b1;          // Stray result, any register
    end else if ((r[10:8] < 3'd3) && (mBusy != '0)) begin
      for (int i = 0; i < numRegs; i++) begin
        if (!mBusy[idx]) idx = idx + regIdxT'(1);  // Walk to a busy one
      end
      writeBack.enable = 1'b1;
    end
    writeBack.regIdx = idx;
    writeBack.data   = (r[15:12] == 4'd0) ? '0 : r[31:16];
  endtask

  initial begin
    I_CLOCK        = 1'b0;
    rst            = 1'b1;
    fetch          = '0;
    writeBack      = '0;
    rngState       = 32'd88;
    held           = 1'b0;
    holdCount      = 0;
    mBusy          = '0;
    mCc            = 3'b010;
    expIssue       = '0;
    expBranchStall = 1'b0;
    foreach (mRegs[i]) mRegs[i] = '0;
    repeat (8) @(posedge I_CLOCK);
    #1;
    rst = 1'b0;
    checkIssue();                       // Nothing issued out of reset
    for (int cyc = 0; cyc < numCycles; cyc++) begin
      @(posedge I_CLOCK);
      #1;
      checkIssue();
      driveInputs();
      #1;
      modelCycle();
      holdCount = held ? holdCount + 1 : 0;
      if (holdCount > stallLimit) begin
        $display("Timeout: fetch held by depStall for more than %0d cycles", stallLimit);
        $display("** FAIL **");
        $fatal(1, "Stall timeout");
      end
    end
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
isaPkg.sv
pipePkg.sv
instrDecoder.sv
registerFile.sv
scoreboard.sv
branchUnit.sv
decodeStage.sv
decodeStage_asserts.sv
tbDecodeStage.sv

// ==== run.sh ====
#!/bin/sh
# Build the decode stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tbDecodeStage -f list.f -o simDecodeStage
./obj_dir/simDecodeStage > sim.log 2>&1 || true
cat sim.log
# Exit status follows the search
grep -qF "** PASS **" sim.log
